// File: verilog/sensor_pkg.sv
// shared constants for the sensor logger
// fsm state encodings and the sample and record structs
package sensor_pkg;

	// hih6121 style humidity/temperature sensor
	localparam logic [6:0] SENSOR_ADDRESS = 7'h27;

	// clocks per quarter of an scl bit
	localparam int I2C_QUARTER_DIVIDE = 8;

	// clocks per uart bit
	localparam int UART_BIT_DIVIDE = 16;

	// clocks between read starts
	localparam int SAMPLE_PERIOD = 8192;

	// 5 + 1 + 5 + 1 + 3 + cr lf
	localparam int LINE_LENGTH = 17;

	// sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_READING,
		SEQ_HANDOVER,
		SEQ_HOLDING
	} seq_state_t;

	// i2c master
	typedef enum logic [2:0] {
		I2C_IDLE,
		I2C_START,
		I2C_ADDRESS,
		I2C_ADDR_ACK,
		I2C_READ_BYTE,
		I2C_MASTER_ACK,
		I2C_STOP
	} i2c_state_t;

	// line formatter
	typedef enum logic [1:0] {
		FMT_IDLE,
		FMT_CONVERTING,
		FMT_SENDING
	} fmt_state_t;

	// four bytes off the wire, byte 0 in the top bits
	typedef struct packed {
		logic [1:0] status;
		logic [13:0] humidity;
		logic [13:0] temperature;
		logic [1:0] pad;
	} sensor_sample_t;

	// one printed line
	typedef struct packed {
		logic [15:0] line_number;
		logic [13:0] raw_temperature;
		logic [7:0] temperature_c;
	} log_record_t;

endpackage

// File: verilog/hex_to_bcd.sv
// iterative double-dabble binary to packed bcd converter
// one bit per cycle, result held until the next start
`timescale 1ns/1ps

module hex_to_bcd #(
	parameter int WIDTH = 16,
	localparam int DIGITS = (WIDTH * 301) / 1000 + 1,
	localparam int COUNT_BITS = $clog2(WIDTH + 1)
) (
	input  logic clock,
	input  logic uart_resetb,
	input  logic bcd_start,
	input  logic [WIDTH-1:0] binary,
	output logic bcd_done,
	output logic [4*DIGITS-1:0] bcd
);
	logic [WIDTH-1:0] shift_binary;
	logic [4*DIGITS-1:0] adjusted;
	logic [COUNT_BITS-1:0] bits_left;
	logic busy;

	// add 3 to every digit above 4 before the shift
	always_comb begin
		adjusted = bcd;
		for (int i = 0; i < DIGITS; i++) begin
			if (bcd[4*i +: 4] > 4'd4)
				adjusted[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
		end
	end

	always_ff @(posedge clock) begin
		bcd_done <= 1'b0;
		if (!uart_resetb) begin
			busy <= 1'b0;
			bits_left <= '0;
		end else if (bcd_start) begin
			busy <= 1'b1;
			bits_left <= COUNT_BITS'(WIDTH);
		end else if (busy) begin
			bits_left <= bits_left - 1'b1;
			// last shift this cycle, digits valid next
			if (bits_left == COUNT_BITS'(1)) begin
				busy <= 1'b0;
				bcd_done <= 1'b1;
			end
		end
	end

	// digits and remaining binary shift as one register
	always_ff @(posedge clock) begin
		if (bcd_start) begin
			shift_binary <= binary;
			bcd <= '0;
		end else if (busy) begin
			{bcd, shift_binary} <= {adjusted, shift_binary} << 1;
		end
	end

endmodule

// File: verilog/i2c_reader.sv
// i2c master for the sensor: start, address with read bit, four bytes, stop
// open-drain sda, quarter-bit timing
`timescale 1ns/1ps

module i2c_reader (
	input  logic clock,
	input  logic uart_resetb,
	input  logic read_start,
	output logic read_done,
	output logic read_nack,
	output sensor_pkg::sensor_sample_t sample,
	output logic scl,
	output logic sda_oe,
	input  logic sda_in
);
	import sensor_pkg::*;

	i2c_state_t state;
	logic [$clog2(I2C_QUARTER_DIVIDE)-1:0] divide_count;
	logic [1:0] quarter;
	logic quarter_end;
	logic bit_end;
	logic sample_point;
	logic scl_high;
	logic [2:0] bit_count;
	logic [1:0] byte_count;
	logic [7:0] address_byte;
	logic [31:0] shift_data;
	logic address_acked;

	// 7-bit address plus read bit
	assign address_byte = {SENSOR_ADDRESS, 1'b1};
	assign quarter_end = int'(divide_count) == I2C_QUARTER_DIVIDE - 1;
	// scl low in q0 and q3, high in q1 and q2
	assign scl_high = (quarter == 2'd1) || (quarter == 2'd2);
	// sample in the middle of the high phase
	assign sample_point = quarter_end && (quarter == 2'd1);
	assign bit_end = quarter_end && (quarter == 2'd3);

	always_ff @(posedge clock) begin
		read_done <= 1'b0;
		read_nack <= 1'b0;
		if (!uart_resetb) begin
			state <= I2C_IDLE;
			divide_count <= '0;
			quarter <= '0;
			bit_count <= '0;
			byte_count <= '0;
			address_acked <= 1'b0;
		end else begin
			// quarter divider, parked while idle
			if (state == I2C_IDLE) begin
				divide_count <= '0;
				quarter <= '0;
			end else if (quarter_end) begin
				divide_count <= '0;
				quarter <= quarter + 2'd1;
			end else begin
				divide_count <= divide_count + 1'b1;
			end
			// target pulls sda low to ack
			if (sample_point && state == I2C_ADDR_ACK)
				address_acked <= !sda_in;
			case (state)
				I2C_IDLE: if (read_start)
					state <= I2C_START;
				I2C_START: if (bit_end) begin
					bit_count <= '0;
					state <= I2C_ADDRESS;
				end
				I2C_ADDRESS: if (bit_end) begin
					// wraps back to 0 after bit 7
					bit_count <= bit_count + 3'd1;
					if (bit_count == 3'd7)
						state <= I2C_ADDR_ACK;
				end
				I2C_ADDR_ACK: if (bit_end) begin
					bit_count <= '0;
					byte_count <= '0;
					state <= address_acked ? I2C_READ_BYTE : I2C_STOP;
				end
				I2C_READ_BYTE: if (bit_end) begin
					bit_count <= bit_count + 3'd1;
					if (bit_count == 3'd7)
						state <= I2C_MASTER_ACK;
				end
				I2C_MASTER_ACK: if (bit_end) begin
					if (byte_count == 2'd3) begin
						state <= I2C_STOP;
					end else begin
						byte_count <= byte_count + 2'd1;
						state <= I2C_READ_BYTE;
					end
				end
				I2C_STOP: if (bit_end) begin
					read_done <= address_acked;
					read_nack <= !address_acked;
					state <= I2C_IDLE;
				end
				default: state <= I2C_IDLE;
			endcase
		end
	end

	// msb first, byte 0 ends up in bits 31:24
	always_ff @(posedge clock) begin
		if (sample_point && state == I2C_READ_BYTE)
			shift_data <= {shift_data[30:0], sda_in};
	end

	assign sample = sensor_sample_t'(shift_data);

	// sda only moves while scl is low, except for start and stop
	always_comb begin
		scl = 1'b1;
		sda_oe = 1'b0;
		case (state)
			I2C_START: begin
				scl = quarter != 2'd3;
				sda_oe = quarter != 2'd0;
			end
			I2C_ADDRESS: begin
				scl = scl_high;
				sda_oe = !address_byte[3'd7 - bit_count];
			end
			I2C_ADDR_ACK, I2C_READ_BYTE: scl = scl_high;
			I2C_MASTER_ACK: begin
				scl = scl_high;
				// ack bytes 0..2, nack the last
				sda_oe = byte_count != 2'd3;
			end
			I2C_STOP: begin
				scl = quarter != 2'd0;
				sda_oe = quarter < 2'd2;
			end
			default: ;
		endcase
	end

	a_done_or_nack: assert property (@(posedge clock) disable iff (!uart_resetb)
		!(read_done && read_nack));

	// sequencer must not start a read while a transaction is running
	a_start_when_idle: assert property (@(posedge clock) disable iff (!uart_resetb)
		read_start |-> state == I2C_IDLE);

endmodule

// File: verilog/line_formatter.sv
// turns a log record into one ascii line
// three bcd converters, then 17 characters with valid/ready
`timescale 1ns/1ps

module line_formatter (
	input  logic clock,
	input  logic uart_resetb,
	input  logic record_valid,
	output logic record_ready,
	input  sensor_pkg::log_record_t record,
	output logic char_valid,
	input  logic char_ready,
	output logic [7:0] char_data
);
	import sensor_pkg::*;

	fmt_state_t state;
	log_record_t held;
	logic bcd_start;
	logic line_done;
	logic raw_done;
	logic temp_done;
	logic [2:0] done_pulse;
	logic [2:0] done_seen;
	logic [19:0] line_bcd;
	logic [19:0] raw_bcd;
	logic [11:0] temp_bcd;
	logic [LINE_LENGTH-1:0][7:0] line_chars;
	logic [$clog2(LINE_LENGTH)-1:0] char_index;

	assign record_ready = state == FMT_IDLE;
	assign char_valid = state == FMT_SENDING;
	assign done_pulse = {temp_done, raw_done, line_done};

	hex_to_bcd #(.WIDTH(16)) i_line_bcd (.clock, .uart_resetb, .bcd_start,
		.binary(held.line_number), .bcd_done(line_done), .bcd(line_bcd));
	// 14-bit raw value, zero padded
	hex_to_bcd #(.WIDTH(16)) i_raw_bcd (.clock, .uart_resetb, .bcd_start,
		.binary({2'b00, held.raw_temperature}), .bcd_done(raw_done), .bcd(raw_bcd));
	hex_to_bcd #(.WIDTH(8)) i_temp_bcd (.clock, .uart_resetb, .bcd_start,
		.binary(held.temperature_c), .bcd_done(temp_done), .bcd(temp_bcd));

	always_ff @(posedge clock) begin
		if (record_valid && record_ready)
			held <= record;
	end

	always_ff @(posedge clock) begin
		bcd_start <= 1'b0;
		if (!uart_resetb) begin
			state <= FMT_IDLE;
			done_seen <= '0;
			char_index <= '0;
		end else begin
			case (state)
				FMT_IDLE: if (record_valid) begin
					bcd_start <= 1'b1;
					done_seen <= '0;
					state <= FMT_CONVERTING;
				end
				FMT_CONVERTING: begin
					// the 8-bit converter finishes first
					done_seen <= done_seen | done_pulse;
					if (&(done_seen | done_pulse)) begin
						char_index <= '0;
						state <= FMT_SENDING;
					end
				end
				FMT_SENDING: if (char_ready) begin
					if (int'(char_index) == LINE_LENGTH - 1) begin
						char_index <= '0;
						state <= FMT_IDLE;
					end else begin
						char_index <= char_index + 1'b1;
					end
				end
				default: state <= FMT_IDLE;
			endcase
		end
	end

	// "nnnnn rrrrr ttt\r\n", most significant digit first
	always_comb begin
		for (int i = 0; i < 5; i++) begin
			line_chars[i] = {4'h3, line_bcd[4*(4-i) +: 4]};
			line_chars[6+i] = {4'h3, raw_bcd[4*(4-i) +: 4]};
		end
		for (int i = 0; i < 3; i++)
			line_chars[12+i] = {4'h3, temp_bcd[4*(2-i) +: 4]};
		line_chars[5] = 8'h20;
		line_chars[11] = 8'h20;
		line_chars[15] = 8'h0d;
		line_chars[16] = 8'h0a;
	end

	assign char_data = line_chars[char_index];

	// bcd outputs must hold while the uart stalls us
	a_char_stable: assert property (@(posedge clock) disable iff (!uart_resetb)
		char_valid && !char_ready |=> $stable(char_data));

endmodule

// File: verilog/uart_tx.sv
// 8n1 uart transmitter with valid/ready character input
// lsb first, tx idles high
`timescale 1ns/1ps

module uart_tx (
	input  logic clock,
	input  logic uart_resetb,
	input  logic char_valid,
	output logic char_ready,
	input  logic [7:0] char_data,
	output logic tx
);
	import sensor_pkg::*;

	logic [$clog2(UART_BIT_DIVIDE)-1:0] divide_count;
	logic [3:0] bits_left;
	logic [9:0] frame;
	logic busy;
	logic bit_end;

	assign char_ready = !busy;
	assign bit_end = int'(divide_count) == UART_BIT_DIVIDE - 1;
	// line stays at mark level between frames
	assign tx = busy ? frame[0] : 1'b1;

	always_ff @(posedge clock) begin
		if (!uart_resetb) begin
			busy <= 1'b0;
			divide_count <= '0;
			bits_left <= '0;
		end else if (!busy) begin
			divide_count <= '0;
			if (char_valid) begin
				// start + 8 data + stop
				busy <= 1'b1;
				bits_left <= 4'd10;
			end
		end else if (bit_end) begin
			divide_count <= '0;
			bits_left <= bits_left - 4'd1;
			if (bits_left == 4'd1)
				busy <= 1'b0;
		end else begin
			divide_count <= divide_count + 1'b1;
		end
	end

	// frame shifts out from bit 0, stop bit refilled from the top
	always_ff @(posedge clock) begin
		if (char_valid && char_ready)
			frame <= {1'b1, char_data, 1'b0};
		else if (busy && bit_end)
			frame <= {1'b1, frame[9:1]};
	end

endmodule

// File: verilog/log_sequencer.sv
// sample period timer and read/record sequencing
// temperature conversion and line numbering
`timescale 1ns/1ps

module log_sequencer (
	input  logic clock,
	input  logic uart_resetb,
	output logic read_start,
	input  logic read_done,
	input  logic read_nack,
	input  sensor_pkg::sensor_sample_t sample,
	output logic record_valid,
	input  logic record_ready,
	output sensor_pkg::log_record_t record,
	output logic sensor_error
);
	import sensor_pkg::*;

	seq_state_t state;
	logic [$clog2(SAMPLE_PERIOD)-1:0] period_count;
	logic period_end;
	logic [15:0] line_count;
	logic [7:0] temperature_c;

	assign period_end = int'(period_count) == SAMPLE_PERIOD - 1;

	// raw/128 + raw/512 - 40 wrapping mod 256
	assign temperature_c = {1'b0, sample.temperature[13:7]}
		+ {3'b000, sample.temperature[13:9]} - 8'd40;

	always_ff @(posedge clock) begin
		read_start <= 1'b0;
		if (!uart_resetb) begin
			state <= SEQ_IDLE;
			period_count <= '0;
			line_count <= 16'd1;
			record_valid <= 1'b0;
			sensor_error <= 1'b0;
		end else begin
			// free-running period counter
			period_count <= period_end ? '0 : period_count + 1'b1;
			case (state)
				SEQ_IDLE: begin
					read_start <= 1'b1;
					state <= SEQ_READING;
				end
				SEQ_READING: if (read_done) begin
					record_valid <= 1'b1;
					line_count <= line_count + 16'd1;
					sensor_error <= 1'b0;
					state <= SEQ_HANDOVER;
				end else if (read_nack) begin
					// no line this period
					sensor_error <= 1'b1;
					state <= SEQ_HOLDING;
				end
				SEQ_HANDOVER: if (record_ready) begin
					record_valid <= 1'b0;
					state <= SEQ_HOLDING;
				end
				// a handover past period end skips that read
				SEQ_HOLDING: if (period_end)
					state <= SEQ_IDLE;
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == SEQ_READING && read_done)
			record <= '{line_number: line_count, raw_temperature: sample.temperature,
				temperature_c: temperature_c};
	end

	a_record_stable: assert property (@(posedge clock) disable iff (!uart_resetb)
		record_valid && !record_ready |=> record_valid && $stable(record));

	// reads start one cycle into a period with no record pending
	a_start_from_idle: assert property (@(posedge clock) disable iff (!uart_resetb)
		read_start |-> !record_valid && period_count == 1);

endmodule

// File: verilog/sensor_logger.sv
// sensor logger top: sequencer, i2c reader, line formatter, uart
`timescale 1ns/1ps

module sensor_logger (
	input  logic clock,
	input  logic uart_resetb,
	output logic scl,
	output logic sda_oe,
	input  logic sda_in,
	output logic tx,
	output logic sensor_error
);
	import sensor_pkg::*;

	// read handshake
	logic read_start;
	logic read_done;
	logic read_nack;
	sensor_sample_t sample;

	// record handshake
	logic record_valid;
	logic record_ready;
	log_record_t record;

	// character stream to the uart
	logic char_valid;
	logic char_ready;
	logic [7:0] char_data;

	log_sequencer i_log_sequencer (.clock, .uart_resetb, .read_start, .read_done, .read_nack,
		.sample, .record_valid, .record_ready, .record, .sensor_error);

	i2c_reader i_i2c_reader (.clock, .uart_resetb, .read_start, .read_done, .read_nack,
		.sample, .scl, .sda_oe, .sda_in);

	line_formatter i_line_formatter (.clock, .uart_resetb, .record_valid, .record_ready,
		.record, .char_valid, .char_ready, .char_data);

	uart_tx i_uart_tx (.clock, .uart_resetb, .char_valid, .char_ready, .char_data, .tx);

endmodule

// File: verif/sensor_model.sv
// behavioral i2c target for the sensor, scripted samples and address refusal
// checks start/stop placement, address byte and master acknowledge order
`timescale 1ns/1ps

module sensor_model (
	input  logic clock,
	input  logic uart_resetb,
	input  logic scl,
	input  logic sda,
	output logic sda_low,
	input  sensor_pkg::sensor_sample_t serve_sample,
	input  logic refuse_address,
	output int start_count,
	output int stop_count,
	output logic protocol_error
);
	import sensor_pkg::*;

	logic scl_q;
	logic sda_q;
	logic active;
	logic reading;
	logic frame_done;
	logic refused;
	logic [3:0] bit_pos;
	logic [2:0] byte_pos;
	logic [7:0] address_shift;
	logic [31:0] serve_shift;
	logic start_seen;
	logic stop_seen;
	logic scl_rise;
	logic scl_fall;

	// bus sampled on negedge, master only moves on posedge
	// any sda edge with scl high shows up as start or stop
	assign start_seen = scl_q && scl && sda_q && !sda;
	assign stop_seen = scl_q && scl && !sda_q && sda;
	assign scl_rise = !scl_q && scl;
	assign scl_fall = scl_q && !scl;

	always @(negedge clock) begin
		scl_q <= scl;
		sda_q <= sda;
		if (!uart_resetb) begin
			sda_low <= 1'b0;
			active <= 1'b0;
			reading <= 1'b0;
			frame_done <= 1'b0;
			bit_pos <= '0;
			byte_pos <= '0;
			start_count <= 0;
			stop_count <= 0;
			protocol_error <= 1'b0;
		end else if (start_seen) begin
			// also catches sda falling mid-byte
			assert (!active) else begin
				$display("start condition inside a running transaction at %0t", $time);
				protocol_error <= 1'b1;
			end
			active <= 1'b1;
			reading <= 1'b0;
			frame_done <= 1'b0;
			bit_pos <= '0;
			byte_pos <= '0;
			refused <= refuse_address;
			serve_shift <= serve_sample;
			start_count <= start_count + 1;
		end else if (stop_seen) begin
			assert (active && frame_done) else begin
				$display("stop condition before the transaction was complete at %0t", $time);
				protocol_error <= 1'b1;
			end
			active <= 1'b0;
			sda_low <= 1'b0;
			stop_count <= stop_count + 1;
		end else if (active && !frame_done && scl_rise) begin
			if (bit_pos < 4'd8) begin
				bit_pos <= bit_pos + 4'd1;
				if (!reading)
					address_shift <= {address_shift[6:0], sda};
			end else if (!reading) begin
				// ninth clock of the address byte
				assert (address_shift == {SENSOR_ADDRESS, 1'b1}) else begin
					$display("MISMATCH %0t: address byte %h, expected %h", $time,
						address_shift, {SENSOR_ADDRESS, 1'b1});
					protocol_error <= 1'b1;
				end
				bit_pos <= '0;
				reading <= !refused;
				frame_done <= refused;
			end else begin
				// ack on bytes 0..2, nack on byte 3
				assert (sda == (byte_pos == 3'd3)) else begin
					$display("MISMATCH %0t: master ack bit %b on byte %0d", $time, sda,
						byte_pos);
					protocol_error <= 1'b1;
				end
				bit_pos <= '0;
				byte_pos <= byte_pos + 3'd1;
				frame_done <= byte_pos == 3'd3;
			end
		end else if (active && scl_fall) begin
			if (!reading) begin
				// pull low for the address ack unless refusing
				sda_low <= bit_pos == 4'd8 && !refused;
			end else if (bit_pos < 4'd8 && byte_pos < 3'd4) begin
				sda_low <= !serve_shift[31];
				serve_shift <= serve_shift << 1;
			end else begin
				sda_low <= 1'b0;
			end
		end
	end

endmodule

// File: verif/tb_sensor_logger.sv
// testbench for the sensor logger with clock, reset and sensor script
// uart line decoder and line checks against the served values
`timescale 1ns/1ps

module tb_sensor_logger;
	import sensor_pkg::*;

	localparam int LINES_EXPECTED = 6;
	localparam int TRANSACTIONS = LINES_EXPECTED + 1;
	localparam int REFUSED_INDEX = 2;
	localparam int WAIT_LIMIT = 4 * SAMPLE_PERIOD;
	localparam int COUNT_STARTS = 0;
	localparam int COUNT_STOPS = 1;
	localparam int COUNT_LINES = 2;

	logic clock;
	logic uart_resetb;
	logic scl;
	logic sda_oe;
	logic sda;
	logic model_sda_low;
	logic tx;
	logic sensor_error;
	logic refuse_address;
	logic protocol_error;
	sensor_sample_t serve_sample;
	sensor_sample_t script_sample [TRANSACTIONS];
	int start_count;
	int stop_count;
	int lines_received;
	logic [7:0] line_chars [$];
	logic [7:0] last_line [$];

	// open-drain sda with a pull-up
	assign sda = !(sda_oe || model_sda_low);

	sensor_logger i_sensor_logger (.clock, .uart_resetb, .scl, .sda_oe, .sda_in(sda), .tx,
		.sensor_error);

	sensor_model i_sensor_model (.clock, .uart_resetb, .scl, .sda, .sda_low(model_sda_low),
		.serve_sample, .refuse_address, .start_count, .stop_count, .protocol_error);

	initial begin
		clock = 1'b0;
		forever #5 clock = !clock;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic int count_of(input int which);
		case (which)
			COUNT_STARTS: return start_count;
			COUNT_STOPS: return stop_count;
			default: return lines_received;
		endcase
	endfunction

	task automatic wait_until(input int which, input int target, input string what);
		int cycles;
		cycles = 0;
		while (count_of(which) < target) begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				fail_run($sformatf("timeout at %0t waiting for %s", $time, what));
		end
	endtask

	// ascii digit of value at a decimal place
	function automatic logic [7:0] digit_char(input int value, input int place);
		return 8'h30 + 8'((value / place) % 10);
	endfunction

	task automatic check_line(input int number, input logic [13:0] raw);
		logic [7:0] expected [LINE_LENGTH];
		int celsius;
		// raw/128 + raw/512 - 40 taken mod 256
		celsius = (int'(raw >> 7) + int'(raw >> 9) - 40 + 256) % 256;
		for (int i = 0; i < 5; i++) begin
			expected[i] = digit_char(number, 10 ** (4 - i));
			expected[6 + i] = digit_char(int'(raw), 10 ** (4 - i));
		end
		for (int i = 0; i < 3; i++)
			expected[12 + i] = digit_char(celsius, 10 ** (2 - i));
		expected[5] = 8'h20;
		expected[11] = 8'h20;
		expected[15] = 8'h0d;
		expected[16] = 8'h0a;
		assert (last_line.size() == LINE_LENGTH) else
			fail_run($sformatf("MISMATCH %0t: line %0d has %0d characters, expected %0d",
				$time, number, last_line.size(), LINE_LENGTH));
		for (int i = 0; i < LINE_LENGTH; i++)
			assert (last_line[i] == expected[i]) else
				fail_run($sformatf("MISMATCH %0t: line %0d char %0d is %h, expected %h",
					$time, number, i, last_line[i], expected[i]));
	endtask

	// tx sampled mid-bit and gathered into lines ending at lf
	initial begin : line_decoder
		logic [7:0] ch;
		int idle;
		lines_received = 0;
		idle = 0;
		while (uart_resetb !== 1'b1) begin
			@(negedge clock);
			idle++;
			if (idle > WAIT_LIMIT)
				fail_run("reset was never released within the timeout");
		end
		forever begin
			idle = 0;
			while (tx !== 1'b0) begin
				@(negedge clock);
				idle++;
				if (idle > WAIT_LIMIT)
					fail_run("no uart start bit arrived within the timeout");
			end
			repeat (UART_BIT_DIVIDE / 2) @(negedge clock);
			assert (tx === 1'b0) else
				fail_run($sformatf("MISMATCH %0t: uart start bit too short", $time));
			// lsb first
			for (int i = 0; i < 8; i++) begin
				repeat (UART_BIT_DIVIDE) @(negedge clock);
				ch[i] = tx;
			end
			repeat (UART_BIT_DIVIDE) @(negedge clock);
			assert (tx === 1'b1) else
				fail_run($sformatf("MISMATCH %0t: uart stop bit is low", $time));
			line_chars.push_back(ch);
			if (ch == 8'h0a) begin
				last_line = line_chars;
				line_chars.delete();
				lines_received++;
			end
		end
	end

	a_model_clean: assert property (@(posedge clock) disable iff (!uart_resetb)
		!protocol_error)
		else fail_run("the sensor model saw a malformed i2c transaction");

	// quiet bus and line until the first start condition
	a_idle_before_read: assert property (@(posedge clock) disable iff (!uart_resetb)
		start_count == 0 |-> tx && scl && !sda_oe && !sensor_error)
		else fail_run($sformatf("MISMATCH %0t: outputs not idle before the first read", $time));

	initial begin : main
		int printed;
		uart_resetb = 1'b0;
		refuse_address = 1'b0;
		printed = 0;
		void'($urandom(32'hd9ed_8813));
		for (int i = 0; i < TRANSACTIONS; i++)
			script_sample[i] = sensor_sample_t'($urandom);
		// both ends of the range where 0 also wraps the celsius value
		script_sample[1].temperature = 14'd0;
		script_sample[3].temperature = 14'd16383;
		serve_sample = script_sample[0];
		repeat (4) @(posedge clock);
		#1;
		assert (tx && scl && !sda_oe && !sensor_error) else
			fail_run($sformatf("MISMATCH %0t: outputs not idle during reset", $time));
		uart_resetb = 1'b1;
		for (int t = 0; t < TRANSACTIONS; t++) begin
			wait_until(COUNT_STOPS, t + 1, "the end of an i2c read");
			// next values in place long before the next start
			@(posedge clock);
			#1;
			if (t + 1 < TRANSACTIONS) begin
				serve_sample = script_sample[t + 1];
				refuse_address = t + 1 == REFUSED_INDEX;
			end
			if (t == REFUSED_INDEX) begin
				wait_until(COUNT_STARTS, t + 2, "the read after the refused one");
				assert (lines_received == printed) else
					fail_run("a uart line was printed for the refused read");
				assert (sensor_error) else
					fail_run($sformatf("MISMATCH %0t: sensor_error low after a refused read",
						$time));
			end else begin
				printed++;
				wait_until(COUNT_LINES, printed, "a uart line");
				check_line(printed, script_sample[t].temperature);
				assert (!sensor_error) else
					fail_run($sformatf("MISMATCH %0t: sensor_error high after a good read",
						$time));
			end
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: project.f
verilog/sensor_pkg.sv
verilog/hex_to_bcd.sv
verilog/i2c_reader.sv
verilog/line_formatter.sv
verilog/uart_tx.sv
verilog/log_sequencer.sv
verilog/sensor_logger.sv
verif/sensor_model.sv
verif/tb_sensor_logger.sv

// File: run_sim.sh
#!/bin/sh
# build the sensor logger testbench with verilator and run it
# the exit status of the simulation is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_sensor_logger -o sim_tb_sensor_logger
./obj_dir/sim_tb_sensor_logger
